// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_lynx_video
FILELIST := lynx_video_top.f
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/clk_gen.sv ====
module clk_gen #(
  parameter int period     = 40,
  parameter int rst_cycles = 5,
  parameter int drive_dly  = 2
) (
  output logic clk_sys,
  output logic rst
);

  initial begin
    clk_sys = 1'b0;
    forever #(period / 2) clk_sys = ~clk_sys;
  end

  initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk_sys);
    #(drive_dly);
    rst = 1'b0; // released off the edge, like every other input
  end

endmodule

// ==== dv/tb_lynx_video.sv ====
module tb_lynx_video
  import lynx_video_pkg::*;
();

  localparam int screen_w           = 8;
  localparam int screen_h           = 4;
  localparam int h_total            = 20;
  localparam int v_total            = 12;
  localparam int pix_div            = 2;
  localparam int v_start            = 3;
  localparam int hs_start           = 12;
  localparam int pause_release_line = 9;
  localparam int tap_limit          = 40;

  localparam int pix_cnt        = screen_w * screen_h;
  localparam int addr_w         = $clog2(pix_cnt);
  localparam int frame_cycles   = h_total * v_total * pix_div;
  localparam int row_cnt        = 6;
  localparam int timeout_cycles = row_cnt * 6 * frame_cycles + 2000; // margin for reset and ff
  localparam int drive_dly      = 2;

  typedef struct {
    logic             buf_en;
    blend_mode_e      mode;
    logic             addr_pat;  // 1 = address-coded, 0 = constant color
    logic             pace;
    logic [pix_w-1:0] color;
  } row_t;

  logic              clk_sys;
  logic              rst;
  logic              pixel_we;
  logic [addr_w-1:0] pixel_addr;
  logic [pix_w-1:0]  pixel_data;
  logic              buffer_en;
  blend_mode_e       blend_mode;
  logic              sync_pace_en;
  logic              ff_en;
  logic              ff_key;
  logic [rgb_w-1:0]  video_rgb;
  logic              video_de;
  logic              video_hs;
  logic              video_vs;
  logic              core_pause;
  logic              fast_forward;

  row_t             rows      [row_cnt];
  logic [rgb_w-1:0] exp_frame [pix_cnt];
  integer           seed      = 34424;
  int               cycle_cnt = 0;
  int               err_cnt   = 0;

  clk_gen #(.period(40), .rst_cycles(5), .drive_dly(drive_dly)) u_clk_gen (.clk_sys, .rst);

  lynx_video_top #(
    .screen_w(screen_w), .screen_h(screen_h), .h_total(h_total), .v_total(v_total),
    .pix_div(pix_div), .v_start(v_start), .hs_start(hs_start),
    .pause_release_line(pause_release_line), .tap_limit(tap_limit)
  ) u_lynx_video_top (
    .clk_sys, .rst, .pixel_we, .pixel_addr, .pixel_data, .buffer_en, .blend_mode,
    .sync_pace_en, .ff_en, .ff_key, .video_rgb, .video_de, .video_hs, .video_vs,
    .core_pause, .fast_forward
  );

  always @(posedge clk_sys) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // reporting and compares

  task automatic abort_run(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rgb(input string name, input logic [rgb_w-1:0] got,
                           input logic [rgb_w-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s expected %06h got %06h", $time, name, exp, got));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got));
    end
  endtask

  ////////////////////
  // reference model

  function automatic logic [pix_w-1:0] pattern_pixel(input row_t row, input int addr);
    if (row.addr_pat) begin
      return row.color ^ pix_w'(addr * 73 + 5); // distinct for every address
    end
    return row.color;
  endfunction

  // every frame in the buffer is the same, so the sums are 2n and 3n
  function automatic logic [rgb_w-1:0] expected_rgb(input blend_mode_e mode,
                                                    input logic [pix_w-1:0] px);
    logic [rgb_w-1:0]      res;
    logic [chan_w-1:0]     n;
    logic [chan_w:0]       s2;
    logic [chan_w+1:0]     s3;
    logic [out_chan_w-1:0] e3;
    int                    scaled;
    for (int c = 0; c < 3; c++) begin
      n  = px[c*chan_w +: chan_w];
      s2 = (chan_w + 1)'(2 * n);
      s3 = (chan_w + 2)'(3 * n);
      e3 = {s3, s3[chan_w+1 -: 2]};
      scaled = (int'(e3) * 21845) / 16384;
      case (mode)
        blend_off: res[c*out_chan_w +: out_chan_w] = {n, n};
        blend_two: res[c*out_chan_w +: out_chan_w] = {s2, s2[chan_w -: 3]};
        default:   res[c*out_chan_w +: out_chan_w] = scaled[out_chan_w-1:0];
      endcase
    end
    return res;
  endfunction

  task automatic load_table();
    rows[0] = '{1'b0, blend_off,   1'b1, 1'b0, 12'h000};
    rows[1] = '{1'b1, blend_two,   1'b0, 1'b1, 12'h5a3};
    rows[2] = '{1'b1, blend_three, 1'b0, 1'b1, 12'hfff};
    rows[3] = '{1'b1, blend_three, 1'b0, 1'b0, pix_w'($random(seed))};
    rows[4] = '{1'b1, blend_two,   1'b0, 1'b1, pix_w'($random(seed))};
    rows[5] = '{1'b0, blend_off,   1'b1, 1'b1, pix_w'($random(seed))};
  endtask

  ////////////////////
  // stimulus

  task automatic step_cycle();
    @(posedge clk_sys);
    #(drive_dly);
  endtask

  // core_pause must stay low while only the scan runs
  task automatic wait_vsync();
    do begin
      step_cycle();
      check_bit("core_pause", core_pause, 1'b0);
    end while (!video_vs);
  endtask

  task automatic write_frame(input row_t row);
    for (int a = 0; a < pix_cnt; a++) begin
      pixel_we   = 1'b1;
      pixel_addr = addr_w'(a);
      pixel_data = pattern_pixel(row, a);
      step_cycle();
      if (a < pix_cnt - 1) begin
        check_bit("core_pause", core_pause, 1'b0); // only the last pixel ends a frame
      end
    end
    pixel_we = 1'b0;
    check_bit("core_pause", core_pause, row.pace);
    while (core_pause) begin
      step_cycle();
      if (video_vs) begin
        abort_run("core_pause was still high at the next vertical sync");
      end
    end
  endtask

  task automatic check_frame();
    int   de_cnt  = 0;
    int   hs_cnt  = 0;
    logic prev_hs = 1'b0;
    logic prev_vs = 1'b1;  // entered on the vsync cycle
    logic done    = 1'b0;
    while (!done) begin
      step_cycle();
      if (video_hs && prev_hs) abort_run("video_hs stayed high for more than one cycle");
      if (video_vs && prev_vs) abort_run("video_vs stayed high for more than one cycle");
      if (video_hs) hs_cnt++;
      if (video_de) begin
        if (de_cnt >= pix_cnt) abort_run("more data-enable cycles than pixels in a frame");
        check_rgb("video_rgb", video_rgb, exp_frame[de_cnt]);
        de_cnt++;
      end else begin
        check_rgb("video_rgb", video_rgb, '0); // black outside the active area
      end
      prev_hs = video_hs;
      prev_vs = video_vs;
      done    = video_vs;
    end
    if (de_cnt != pix_cnt) begin
      abort_run($sformatf("frame had %0d data-enable cycles instead of %0d", de_cnt, pix_cnt));
    end
    if (hs_cnt != v_total) begin
      abort_run($sformatf("frame had %0d hsync pulses instead of %0d", hs_cnt, v_total));
    end
  endtask

  task automatic run_row(input row_t row);
    buffer_en    = row.buf_en;
    blend_mode   = row.mode;
    sync_pace_en = row.pace;
    for (int k = 0; k < pix_cnt; k++) begin
      exp_frame[k] = expected_rgb(row.mode, pattern_pixel(row, k));
    end
    repeat (3) begin
      write_frame(row);
      wait_vsync();
    end
    wait_vsync(); // two vsyncs after the last write, counting the one above
    check_frame();
  endtask

  ////////////////////
  // fast forward

  task automatic press_key(input int cycles, input logic exp_held);
    ff_key = 1'b1;
    repeat (cycles) begin
      step_cycle();
      check_bit("fast_forward", fast_forward, exp_held);
    end
    ff_key = 1'b0;
  endtask

  task automatic check_after_release(input logic exp);
    repeat (2) step_cycle();   // release cycle still shows the key
    repeat (10) begin
      step_cycle();
      check_bit("fast_forward", fast_forward, exp);
    end
  endtask

  task automatic test_fast_forward();
    ff_en = 1'b1;
    step_cycle();
    press_key(10, 1'b1);
    check_after_release(1'b1);   // first tap latches
    press_key(10, 1'b1);
    check_after_release(1'b0);   // second tap clears
    press_key(10, 1'b1);
    check_after_release(1'b1);
    press_key(100, 1'b1);
    check_after_release(1'b0);   // long hold drops the latch, momentary only
    press_key(10, 1'b1);
    check_after_release(1'b1);
    ff_en = 1'b0;                // disable wipes the latch too
    step_cycle();
    check_bit("fast_forward", fast_forward, 1'b0);
    press_key(10, 1'b0);
    check_after_release(1'b0);
  endtask

  initial begin
    pixel_we     = 1'b0;
    pixel_addr   = '0;
    pixel_data   = '0;
    buffer_en    = 1'b0;
    blend_mode   = blend_off;
    sync_pace_en = 1'b0;
    ff_en        = 1'b0;
    ff_key       = 1'b0;
    load_table();

    @(negedge rst);
    check_bit("video_de", video_de, 1'b0);
    check_bit("video_hs", video_hs, 1'b0);
    check_bit("video_vs", video_vs, 1'b0);
    check_bit("core_pause", core_pause, 1'b0);
    check_bit("fast_forward", fast_forward, 1'b0);

    wait_vsync();
    for (int r = 0; r < row_cnt; r++) begin
      run_row(rows[r]);
    end
    test_fast_forward();

    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== lynx_video_top.f ====
source/lynx_video_pkg.sv
source/frame_buffer.sv
source/flicker_blend.sv
source/scan_timing.sv
source/sync_shaper.sv
source/ff_latch.sv
source/lynx_video_top.sv
dv/clk_gen.sv
dv/tb_lynx_video.sv

// ==== source/ff_latch.sv ====
module ff_latch #(
  parameter int tap_limit = 6400000,  // 0.1 s at 64 MHz
  localparam int cnt_w    = $clog2(tap_limit + 1)
) (
  input  logic clk_sys,
  input  logic rst,
  input  logic ff_en,
  input  logic ff_key,
  output logic fast_forward
);

  logic             key;
  logic             key_prev;
  logic             tap_latch;
  logic [cnt_w-1:0] hold_cnt;
  logic             hold_long;

  assign key       = ff_en && ff_key;
  assign hold_long = (hold_cnt == cnt_w'(tap_limit));

  always_ff @(posedge clk_sys) begin
    if (rst || !ff_en) begin
      key_prev     <= 1'b0;
      tap_latch    <= 1'b0;
      hold_cnt     <= '0;
      fast_forward <= 1'b0;
    end else begin
      key_prev     <= key;
      fast_forward <= key || key_prev || tap_latch; // key_prev covers the release cycle

      if (key && !key_prev) begin
        hold_cnt <= '0;
      end else if (key && !hold_long) begin
        hold_cnt <= hold_cnt + 1'b1; // saturates at the limit
      end

      if (key && hold_long) begin
        tap_latch <= 1'b0;           // long hold, momentary only
      end else if (!key && key_prev && !hold_long) begin
        tap_latch <= !tap_latch;     // short tap
      end
    end
  end

endmodule

// ==== source/flicker_blend.sv ====
module flicker_blend
  import lynx_video_pkg::*;
(
  input  logic             clk_sys,
  input  logic             rst,
  input  logic             ce_pix,
  input  blend_mode_e      blend_mode,
  input  bank_sel_e        read_bank,
  input  bank_sel_e        last_bank,
  input  logic [pix_w-1:0] rgb_bank0,
  input  logic [pix_w-1:0] rgb_bank1,
  input  logic [pix_w-1:0] rgb_bank2,
  output logic [rgb_w-1:0] pix_rgb
);

  localparam int chan_cnt = pix_w / chan_w;

  logic [pix_w-1:0]                     cur_px;
  logic [pix_w-1:0]                     last_px;
  logic [chan_cnt-1:0][out_chan_w-1:0]  blend_rgb;

  function automatic logic [pix_w-1:0] pick_bank(bank_sel_e sel, logic [pix_w-1:0] b0,
                                                 logic [pix_w-1:0] b1, logic [pix_w-1:0] b2);
    logic [pix_w-1:0] px;
    case (sel)
      bank_0:  px = b0;
      bank_1:  px = b1;
      default: px = b2;
    endcase
    return px;
  endfunction

  assign cur_px  = pick_bank(read_bank, rgb_bank0, rgb_bank1, rgb_bank2);
  assign last_px = pick_bank(last_bank, rgb_bank0, rgb_bank1, rgb_bank2);

  for (genvar c = 0; c < chan_cnt; c++) begin : g_chan
    logic [chan_w-1:0]     cur_c;
    logic [chan_w-1:0]     last_c;
    logic [chan_w:0]       sum2;  // two frames, 5 bits
    logic [chan_w+1:0]     sum3;  // three frames, 6 bits
    logic [out_chan_w-1:0] ext3;
    logic [23:0]           mul3;

    assign cur_c  = cur_px[c*chan_w +: chan_w];
    assign last_c = last_px[c*chan_w +: chan_w];
    assign sum2   = {1'b0, cur_c} + {1'b0, last_c};
    assign sum3   = {2'b0, rgb_bank0[c*chan_w +: chan_w]}
                  + {2'b0, rgb_bank1[c*chan_w +: chan_w]}
                  + {2'b0, rgb_bank2[c*chan_w +: chan_w]};
    assign ext3   = {sum3, sum3[chan_w+1 -: 2]};
    assign mul3   = ext3 * 24'd21845; // x4/3 scale, then /16384 below

    assign blend_rgb[c] = (blend_mode == blend_off) ? {cur_c, cur_c} :
                          (blend_mode == blend_two) ? {sum2, sum2[chan_w -: 3]} :
                                                      mul3[14 +: out_chan_w];
  end

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      pix_rgb <= '0;
    end else if (ce_pix) begin
      pix_rgb <= blend_rgb;
    end
  end

endmodule

// ==== source/frame_buffer.sv ====
module frame_buffer
  import lynx_video_pkg::*;
#(
  parameter int screen_w           = 160,
  parameter int screen_h           = 102,
  parameter int pause_release_line = 150,
  parameter int line_w             = 9,
  localparam int pix_cnt           = screen_w * screen_h,
  localparam int addr_w            = $clog2(pix_cnt)
) (
  input  logic              clk_sys,
  input  logic              rst,
  input  logic              buffer_en,
  input  logic              sync_pace_en,
  input  logic              pixel_we,
  input  logic [addr_w-1:0] pixel_addr,
  input  logic [pix_w-1:0]  pixel_data,
  input  logic [addr_w-1:0] read_addr,
  input  logic              frame_tick,
  input  logic [line_w-1:0] line_y,
  output logic [pix_w-1:0]  rgb_bank0,
  output logic [pix_w-1:0]  rgb_bank1,
  output logic [pix_w-1:0]  rgb_bank2,
  output bank_sel_e         read_bank,
  output bank_sel_e         last_bank,
  output logic              core_pause
);

  bank_sel_e wr_bank;    // bank the core is filling
  bank_sel_e next_bank;  // last finished frame, shown from next frame_tick
  bank_sel_e wr_bank_nxt;
  logic      frame_done;

  assign frame_done = pixel_we && (pixel_addr == addr_w'(pix_cnt - 1));

  // rotate 0 -> 1 -> 2 -> 0
  assign wr_bank_nxt = (wr_bank == bank_sel_e'(bank_cnt - 1)) ? bank_0
                                                             : bank_sel_e'(wr_bank + 2'd1);

  ////////////////////
  // pixel banks

  for (genvar g = 0; g < bank_cnt; g++) begin : g_bank
    logic [pix_w-1:0] vram [pix_cnt];
    logic [pix_w-1:0] rd_q;

    always_ff @(posedge clk_sys) begin
      if (pixel_we && wr_bank == bank_sel_e'(g)) begin
        vram[pixel_addr] <= pixel_data;
      end
      rd_q <= vram[read_addr]; // one cycle read latency
    end
  end

  assign rgb_bank0 = g_bank[0].rd_q;
  assign rgb_bank1 = g_bank[1].rd_q;
  assign rgb_bank2 = g_bank[2].rd_q;

  ////////////////////
  // bank rotation and handoff

  always_ff @(posedge clk_sys) begin
    if (rst || !buffer_en) begin
      wr_bank   <= bank_0; // single bank mode
      next_bank <= bank_0;
    end else if (frame_done) begin
      next_bank <= wr_bank;
      wr_bank   <= wr_bank_nxt;
    end
  end

  // scan side only switches at the top of the frame
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      read_bank <= bank_0;
      last_bank <= bank_0;
    end else if (frame_tick) begin
      read_bank <= next_bank;
      last_bank <= read_bank;
    end
  end

  // hold the core after a finished frame until the beam is past the release line
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      core_pause <= 1'b0;
    end else if (line_y > pause_release_line) begin
      core_pause <= 1'b0;
    end else if (sync_pace_en && frame_done) begin
      core_pause <= 1'b1;
    end
  end

endmodule

// ==== source/lynx_video_pkg.sv ====
package lynx_video_pkg;

  ////////////////////
  // pixel and color widths

  localparam int chan_w     = 4;          // one stored channel
  localparam int pix_w      = 3 * chan_w; // r, g, b nibbles, red on top
  localparam int out_chan_w = 8;          // one output channel
  localparam int rgb_w      = 3 * out_chan_w;

  ////////////////////
  // frame buffer

  localparam int bank_cnt = 3;

  // flicker blend setting, same field values as the runtime setting
  typedef enum logic [1:0] {
    blend_off   = 2'd0,   // current frame only
    blend_two   = 2'd1,   // current and previous frame
    blend_three = 2'd2    // all three banks
  } blend_mode_e;

  // frame buffer bank index
  typedef enum logic [1:0] {
    bank_0 = 2'd0,
    bank_1 = 2'd1,
    bank_2 = 2'd2
  } bank_sel_e;

endpackage

// ==== source/lynx_video_top.sv ====
module lynx_video_top
  import lynx_video_pkg::*;
#(
  parameter int screen_w           = 160,
  parameter int screen_h           = 102,
  parameter int h_total            = 445,
  parameter int v_total            = 270,
  parameter int pix_div            = 9,
  parameter int v_start            = 120,
  parameter int hs_start           = 350,
  parameter int pause_release_line = 150,
  parameter int tap_limit          = 6400000,
  localparam int addr_w            = $clog2(screen_w * screen_h),
  localparam int line_w            = $clog2(v_total)
) (
  input  logic              clk_sys,
  input  logic              rst,
  input  logic              pixel_we,
  input  logic [addr_w-1:0] pixel_addr,
  input  logic [pix_w-1:0]  pixel_data,
  input  logic              buffer_en,
  input  blend_mode_e       blend_mode,
  input  logic              sync_pace_en,
  input  logic              ff_en,
  input  logic              ff_key,
  output logic [rgb_w-1:0]  video_rgb,
  output logic              video_de,
  output logic              video_hs,
  output logic              video_vs,
  output logic              core_pause,
  output logic              fast_forward
);

  logic              ce_pix;
  logic              hbl;
  logic              vbl;
  logic              hs_raw;
  logic              vs_raw;
  logic              frame_tick;
  logic [addr_w-1:0] read_addr;
  logic [line_w-1:0] line_y;
  logic [pix_w-1:0]  rgb_bank0;
  logic [pix_w-1:0]  rgb_bank1;
  logic [pix_w-1:0]  rgb_bank2;
  bank_sel_e         read_bank;
  bank_sel_e         last_bank;
  logic [rgb_w-1:0]  pix_rgb;

  frame_buffer #(
    .screen_w(screen_w), .screen_h(screen_h),
    .pause_release_line(pause_release_line), .line_w(line_w)
  ) u_frame_buffer (
    .clk_sys, .rst, .buffer_en, .sync_pace_en, .pixel_we, .pixel_addr, .pixel_data,
    .read_addr, .frame_tick, .line_y, .rgb_bank0, .rgb_bank1, .rgb_bank2,
    .read_bank, .last_bank, .core_pause
  );

  flicker_blend u_flicker_blend (
    .clk_sys, .rst, .ce_pix, .blend_mode, .read_bank, .last_bank,
    .rgb_bank0, .rgb_bank1, .rgb_bank2, .pix_rgb
  );

  scan_timing #(
    .screen_w(screen_w), .screen_h(screen_h), .h_total(h_total), .v_total(v_total),
    .pix_div(pix_div), .v_start(v_start), .hs_start(hs_start)
  ) u_scan_timing (
    .clk_sys, .rst, .ce_pix, .hbl, .vbl, .hs_raw, .vs_raw, .read_addr, .line_y, .frame_tick
  );

  sync_shaper u_sync_shaper (
    .clk_sys, .rst, .hbl, .vbl, .hs_raw, .vs_raw, .pix_rgb,
    .video_rgb, .video_de, .video_hs, .video_vs
  );

  ff_latch #(
    .tap_limit(tap_limit)
  ) u_ff_latch (
    .clk_sys, .rst, .ff_en, .ff_key, .fast_forward
  );

endmodule

// ==== source/scan_timing.sv ====
module scan_timing #(
  parameter int screen_w  = 160,
  parameter int screen_h  = 102,
  parameter int h_total   = 445,
  parameter int v_total   = 270,
  parameter int pix_div   = 9,
  parameter int v_start   = 120,
  parameter int hs_start  = 350,
  localparam int addr_w   = $clog2(screen_w * screen_h),
  localparam int line_w   = $clog2(v_total),
  localparam int x_w      = $clog2(h_total),
  localparam int div_w    = $clog2(pix_div + 1)
) (
  input  logic              clk_sys,
  input  logic              rst,
  output logic              ce_pix,
  output logic              hbl,
  output logic              vbl,
  output logic              hs_raw,
  output logic              vs_raw,
  output logic [addr_w-1:0] read_addr,
  output logic [line_w-1:0] line_y,
  output logic              frame_tick
);

  localparam int hs_len = 32; // pixels

  logic [div_w-1:0]  div;
  logic [x_w-1:0]    x;
  logic [line_w-1:0] y;
  logic              x_act;
  logic              y_act;
  logic              line_end;

  ////////////////////
  // pixel clock enable

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      div <= '0;
    end else if (div == div_w'(pix_div - 1)) begin
      div <= '0;
    end else begin
      div <= div + 1'b1;
    end
  end

  assign ce_pix = (div == '0);

  ////////////////////
  // beam counters

  assign line_end   = (x == x_w'(h_total - 1));
  assign frame_tick = ce_pix && line_end && (y == line_w'(v_total - 1));

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      x <= '0;
      y <= '0;
    end else if (ce_pix) begin
      if (line_end) begin
        x <= '0;
        y <= (y == line_w'(v_total - 1)) ? '0 : y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  assign x_act = (x < screen_w);
  assign y_act = (y >= v_start) && (y < v_start + screen_h);

  // hbl drops for one cycle per active pixel, right after its strobe
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      hbl <= 1'b1;
      vbl <= 1'b1;
    end else begin
      hbl <= !(ce_pix && x_act);
      vbl <= !y_act;
    end
  end

  // landscape read order, one address per active pixel
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      read_addr <= '0;
    end else if (ce_pix) begin
      if (!y_act) begin
        read_addr <= '0;
      end else if (x_act) begin
        read_addr <= read_addr + 1'b1;
      end
    end
  end

  assign hs_raw = (x >= hs_start) && (x < hs_start + hs_len);
  assign vs_raw = (y >= 1) && (y <= 4);   // lines 1 to 4
  assign line_y = y;

endmodule

// ==== source/sync_shaper.sv ====
module sync_shaper
  import lynx_video_pkg::*;
(
  input  logic             clk_sys,
  input  logic             rst,
  input  logic             hbl,
  input  logic             vbl,
  input  logic             hs_raw,
  input  logic             vs_raw,
  input  logic [rgb_w-1:0] pix_rgb,
  output logic [rgb_w-1:0] video_rgb,
  output logic             video_de,
  output logic             video_hs,
  output logic             video_vs
);

  localparam int hs_lag = 7; // keeps hsync clear of the vsync edge

  logic       de;
  logic       hs_prev;
  logic       vs_prev;
  logic [2:0] hs_delay;

  assign de = !hbl && !vbl;

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      hs_delay  <= '0;
    end else begin
      video_de  <= de;
      video_rgb <= de ? pix_rgb : '0;   // black outside active area
      video_vs  <= vs_raw && !vs_prev;  // single cycle on the rise
      video_hs  <= (hs_delay == 3'd1);
      hs_prev   <= hs_raw;
      vs_prev   <= vs_raw;

      // delayed hsync
      if (hs_raw && !hs_prev) begin
        hs_delay <= 3'(hs_lag - 1);
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end
    end
  end

endmodule
